/* verilog/dcache_pkg.sv */
package dcache_pkg;

    // Word and address widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int MASK_W = DATA_W / 8;

    // Line geometry
    localparam int OFFSET_W       = 4;
    localparam int WORD_W         = 2;
    localparam int BYTE_OFF_W     = OFFSET_W - WORD_W;
    localparam int WORDS_PER_LINE = 1 << WORD_W;
    localparam int INDEX_W        = 4;
    localparam int NUM_SETS       = 1 << INDEX_W;
    localparam int TAG_W          = ADDR_W - INDEX_W - OFFSET_W;
    localparam int WAYS           = 2;

    // Write buffer
    localparam int WB_DEPTH = 4;
    localparam int WB_PTR_W = $clog2(WB_DEPTH);

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [DATA_W-1:0]  data_t;
    typedef logic [MASK_W-1:0]  mask_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [WORD_W-1:0]  word_t;
    typedef logic [TAG_W-1:0]   tag_t;

    typedef enum logic [1:0] {
        MEM_IDLE  = 2'd0,
        MEM_READ  = 2'd1,
        MEM_WRITE = 2'd2
    } mem_cmd_t;

endpackage

/* verilog/dcache_way_ram.sv */
`timescale 1ns/1ps

module dcache_way_ram (
    input  logic               clk,
    input  logic               i_wr_en,
    input  dcache_pkg::index_t i_wr_index,
    input  dcache_pkg::word_t  i_wr_word,
    input  dcache_pkg::mask_t  i_wr_mask,
    input  dcache_pkg::data_t  i_wr_data,
    input  dcache_pkg::index_t i_rd_index,
    input  dcache_pkg::word_t  i_rd_word,
    output dcache_pkg::data_t  o_rd_data
);
    import dcache_pkg::*;

    data_t mem_q [NUM_SETS][WORDS_PER_LINE];
    data_t merged;

    // Old word with the enabled bytes replaced
    always_comb begin
        merged = mem_q[i_wr_index][i_wr_word];
        for (int b = 0; b < MASK_W; b++) begin
            if (i_wr_mask[b]) merged[8*b +: 8] = i_wr_data[8*b +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (i_wr_en) mem_q[i_wr_index][i_wr_word] <= merged;
        // Write-first on a same-word collision
        if (i_wr_en && i_wr_index == i_rd_index && i_wr_word == i_rd_word) begin
            o_rd_data <= merged;
        end else begin
            o_rd_data <= mem_q[i_rd_index][i_rd_word];
        end
    end

endmodule

/* verilog/dcache_front.sv */
`timescale 1ns/1ps

module dcache_front (
    input  logic               clk,
    input  logic               rst,
    input  logic               i_read,
    input  dcache_pkg::addr_t  i_read_addr,
    input  logic               i_write,
    input  dcache_pkg::addr_t  i_write_addr,
    input  dcache_pkg::data_t  i_write_data,
    input  dcache_pkg::mask_t  i_write_mask,
    input  logic               i_wb_full,
    input  logic               i_fill_valid,
    input  dcache_pkg::word_t  i_fill_word,
    input  dcache_pkg::data_t  i_fill_data,
    input  logic               i_fill_last,
    output logic               o_read_done,
    output dcache_pkg::data_t  o_read_data,
    output logic               o_write_done,
    output logic               o_wb_push,
    output dcache_pkg::addr_t  o_wb_push_addr,
    output dcache_pkg::data_t  o_wb_push_data,
    output dcache_pkg::mask_t  o_wb_push_mask,
    output logic               o_miss_req,
    output dcache_pkg::addr_t  o_miss_addr,
    output logic               o_miss_way
);
    import dcache_pkg::*;

    tag_t             tag_q   [NUM_SETS][WAYS];
    logic [WAYS-1:0]  valid_q [NUM_SETS];
    logic             lru_q   [NUM_SETS];

    addr_t            req_addr;
    index_t           req_index;
    index_t           miss_index;
    logic [WAYS-1:0]  way_hit;
    logic             hit;
    logic             victim;
    logic             rd_accept;
    logic             wr_accept;

    logic             rd_done_q;
    logic             wr_done_q;
    logic             sel_way_q;
    logic             miss_q;
    logic             first_q;
    logic             miss_way_q;
    addr_t            miss_addr_q;

    data_t            way_rd_data [WAYS];
    logic [WAYS-1:0]  way_wr_en;
    index_t           ram_wr_index;
    word_t            ram_wr_word;
    mask_t            ram_wr_mask;
    data_t            ram_wr_data;

    ////////////////////////////////////////
    // Lookup
    ////////////////////////////////////////
    assign req_addr   = i_write ? i_write_addr : i_read_addr;
    assign req_index  = req_addr[OFFSET_W +: INDEX_W];
    assign miss_index = miss_addr_q[OFFSET_W +: INDEX_W];

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            way_hit[w] = valid_q[req_index][w] &&
                         tag_q[req_index][w] == req_addr[ADDR_W-1 -: TAG_W];
        end
    end

    assign hit       = |way_hit;
    // Way not most recently used
    assign victim    = lru_q[req_index];
    assign rd_accept = i_read && !rd_done_q && !miss_q;
    assign wr_accept = i_write && !wr_done_q && !miss_q && !i_wb_full;

    ////////////////////////////////////////
    // Data ways
    ////////////////////////////////////////
    assign ram_wr_index = miss_q ? miss_index : req_index;
    assign ram_wr_word  = miss_q ? i_fill_word : i_write_addr[BYTE_OFF_W +: WORD_W];
    assign ram_wr_mask  = miss_q ? '1 : i_write_mask;
    assign ram_wr_data  = miss_q ? i_fill_data : i_write_data;

    for (genvar w = 0; w < WAYS; w++) begin : g_way
        assign way_wr_en[w] = miss_q ? (i_fill_valid && miss_way_q == w) :
                                       (wr_accept && way_hit[w]);

        dcache_way_ram way_ram_i (
            .clk        (clk),
            .i_wr_en    (way_wr_en[w]),
            .i_wr_index (ram_wr_index),
            .i_wr_word  (ram_wr_word),
            .i_wr_mask  (ram_wr_mask),
            .i_wr_data  (ram_wr_data),
            .i_rd_index (i_read_addr[OFFSET_W +: INDEX_W]),
            .i_rd_word  (i_read_addr[BYTE_OFF_W +: WORD_W]),
            .o_rd_data  (way_rd_data[w])
        );
    end

    ////////////////////////////////////////
    // Control and tag state
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_done_q <= 1'b0;
            wr_done_q <= 1'b0;
            sel_way_q <= 1'b0;
            miss_q    <= 1'b0;
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_q[s] <= '0;
                lru_q[s]   <= 1'b0;
            end
        end else begin
            rd_done_q <= 1'b0;
            wr_done_q <= wr_accept;
            if (rd_accept && hit) begin
                rd_done_q        <= 1'b1;
                sel_way_q        <= way_hit[1];
                lru_q[req_index] <= !way_hit[1];
            end
            if (rd_accept && !hit) begin
                miss_q      <= 1'b1;
                first_q     <= 1'b1;
                miss_addr_q <= i_read_addr;
                miss_way_q  <= victim;
            end
            if (wr_accept && hit) lru_q[req_index] <= !way_hit[1];
            if (miss_q && i_fill_valid) begin
                first_q <= 1'b0;
                // Critical word comes back through the RAM bypass
                if (first_q) begin
                    rd_done_q <= 1'b1;
                    sel_way_q <= miss_way_q;
                end
                if (i_fill_last) begin
                    miss_q                          <= 1'b0;
                    valid_q[miss_index][miss_way_q] <= 1'b1;
                    tag_q[miss_index][miss_way_q]   <= miss_addr_q[ADDR_W-1 -: TAG_W];
                    lru_q[miss_index]               <= !miss_way_q;
                end
            end
        end
    end

    assign o_read_done    = rd_done_q;
    assign o_read_data    = way_rd_data[sel_way_q];
    assign o_write_done   = wr_done_q;
    assign o_wb_push      = wr_accept;
    assign o_wb_push_addr = i_write_addr;
    assign o_wb_push_data = i_write_data;
    assign o_wb_push_mask = i_write_mask;
    assign o_miss_req     = miss_q;
    assign o_miss_addr    = miss_addr_q;
    assign o_miss_way     = miss_way_q;

endmodule

/* verilog/dcache_write_buffer.sv */
`timescale 1ns/1ps

module dcache_write_buffer (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_push,
    input  dcache_pkg::addr_t i_push_addr,
    input  dcache_pkg::data_t i_push_data,
    input  dcache_pkg::mask_t i_push_mask,
    input  logic              i_pop,
    output logic              o_full,
    output logic              o_empty,
    output dcache_pkg::addr_t o_head_addr,
    output dcache_pkg::data_t o_head_data,
    output dcache_pkg::mask_t o_head_mask
);
    import dcache_pkg::*;

    addr_t                addr_q [WB_DEPTH];
    data_t                data_q [WB_DEPTH];
    mask_t                mask_q [WB_DEPTH];
    logic [WB_DEPTH-1:0]  valid_q;
    logic [WB_PTR_W-1:0]  head_q;
    logic [WB_PTR_W-1:0]  tail_q;
    logic [WB_PTR_W:0]    count_q;

    addr_t                push_word;
    logic                 merge_hit;
    logic [WB_PTR_W-1:0]  merge_idx;
    logic                 alloc;

    assign push_word = {i_push_addr[ADDR_W-1:BYTE_OFF_W], {BYTE_OFF_W{1'b0}}};

    // Head may be on the memory bus, so it never takes a merge
    always_comb begin
        merge_hit = 1'b0;
        merge_idx = '0;
        for (int i = 0; i < WB_DEPTH; i++) begin
            if (valid_q[i] && addr_q[i] == push_word && WB_PTR_W'(i) != head_q) begin
                merge_hit = 1'b1;
                merge_idx = WB_PTR_W'(i);
            end
        end
    end

    assign alloc = i_push && !merge_hit && !o_full;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (alloc) begin
                valid_q[tail_q] <= 1'b1;
                tail_q          <= tail_q + 1'b1;
            end
            if (i_pop) begin
                valid_q[head_q] <= 1'b0;
                head_q          <= head_q + 1'b1;
            end
            count_q <= count_q + (WB_PTR_W+1)'(alloc) - (WB_PTR_W+1)'(i_pop);
        end
    end

    ////////////////////////////////////////
    // Entry payload
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (alloc) begin
            addr_q[tail_q] <= push_word;
            data_q[tail_q] <= i_push_data;
            mask_q[tail_q] <= i_push_mask;
        end else if (i_push && merge_hit) begin
            for (int b = 0; b < MASK_W; b++) begin
                if (i_push_mask[b]) data_q[merge_idx][8*b +: 8] <= i_push_data[8*b +: 8];
            end
            mask_q[merge_idx] <= mask_q[merge_idx] | i_push_mask;
        end
    end

    assign o_full      = count_q == (WB_PTR_W+1)'(WB_DEPTH);
    assign o_empty     = count_q == '0;
    assign o_head_addr = addr_q[head_q];
    assign o_head_data = data_q[head_q];
    assign o_head_mask = mask_q[head_q];

endmodule

/* verilog/dcache_mem_seq.sv */
`timescale 1ns/1ps

module dcache_mem_seq (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 i_wb_empty,
    input  dcache_pkg::addr_t    i_wb_head_addr,
    input  dcache_pkg::data_t    i_wb_head_data,
    input  dcache_pkg::mask_t    i_wb_head_mask,
    input  logic                 i_miss_req,
    input  dcache_pkg::addr_t    i_miss_addr,
    input  logic                 i_mem_ready,
    input  logic                 i_mem_rvalid,
    input  dcache_pkg::data_t    i_mem_rdata,
    output logic                 o_wb_pop,
    output dcache_pkg::mem_cmd_t o_mem_cmd,
    output dcache_pkg::addr_t    o_mem_addr,
    output dcache_pkg::data_t    o_mem_wdata,
    output dcache_pkg::mask_t    o_mem_mask,
    output logic                 o_fill_valid,
    output dcache_pkg::word_t    o_fill_word,
    output dcache_pkg::data_t    o_fill_data,
    output logic                 o_fill_last
);
    import dcache_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_DRAIN,
        ST_REFILL
    } state_t;

    state_t                       state_q;
    logic [ADDR_W-OFFSET_W-1:0]   line_q;
    word_t                        word_q;
    word_t                        count_q;
    logic                         got_word;

    assign got_word = state_q == ST_REFILL && i_mem_rvalid;

    ////////////////////////////////////////
    // Memory bus
    ////////////////////////////////////////
    always_comb begin
        o_mem_cmd   = MEM_IDLE;
        o_mem_addr  = {line_q, word_q, {BYTE_OFF_W{1'b0}}};
        o_mem_wdata = i_wb_head_data;
        o_mem_mask  = i_wb_head_mask;
        case (state_q)
            ST_DRAIN: begin
                o_mem_cmd  = MEM_WRITE;
                o_mem_addr = i_wb_head_addr;
            end
            ST_REFILL: begin
                o_mem_cmd = MEM_READ;
            end
            default: begin
                o_mem_cmd = MEM_IDLE;
            end
        endcase
    end

    // Pop on the edge that accepts the write
    assign o_wb_pop     = state_q == ST_DRAIN && i_mem_ready;

    assign o_fill_valid = got_word;
    assign o_fill_word  = word_q;
    assign o_fill_data  = i_mem_rdata;
    assign o_fill_last  = got_word && count_q == word_t'(WORDS_PER_LINE - 1);

    ////////////////////////////////////////
    // Sequencer FSM
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ST_IDLE;
            count_q <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    // Stores go out before any refill
                    if (!i_wb_empty) begin
                        state_q <= ST_DRAIN;
                    end else if (i_miss_req) begin
                        state_q <= ST_REFILL;
                        count_q <= '0;
                    end
                end
                ST_DRAIN: begin
                    if (i_mem_ready) state_q <= ST_IDLE;
                end
                ST_REFILL: begin
                    if (i_mem_rvalid) begin
                        count_q <= count_q + 1'b1;
                        if (o_fill_last) state_q <= ST_IDLE;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // Critical word first, then wrap around the line
    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && i_wb_empty && i_miss_req) begin
            line_q <= i_miss_addr[ADDR_W-1:OFFSET_W];
            word_q <= i_miss_addr[BYTE_OFF_W +: WORD_W];
        end else if (got_word) begin
            word_q <= word_q + 1'b1;
        end
    end

endmodule

/* verilog/dcache_top.sv */
`timescale 1ns/1ps

module dcache_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 i_read,
    input  dcache_pkg::addr_t    i_read_addr,
    output logic                 o_read_done,
    output dcache_pkg::data_t    o_read_data,
    input  logic                 i_write,
    input  dcache_pkg::addr_t    i_write_addr,
    input  dcache_pkg::data_t    i_write_data,
    input  dcache_pkg::mask_t    i_write_mask,
    output logic                 o_write_done,
    output dcache_pkg::mem_cmd_t o_mem_cmd,
    output dcache_pkg::addr_t    o_mem_addr,
    output dcache_pkg::data_t    o_mem_wdata,
    output dcache_pkg::mask_t    o_mem_mask,
    input  logic                 i_mem_ready,
    input  logic                 i_mem_rvalid,
    input  dcache_pkg::data_t    i_mem_rdata
);
    import dcache_pkg::*;

    // Front end to write buffer
    logic   wb_push;
    addr_t  wb_push_addr;
    data_t  wb_push_data;
    mask_t  wb_push_mask;
    logic   wb_full;

    // Write buffer to sequencer
    logic   wb_empty;
    logic   wb_pop;
    addr_t  wb_head_addr;
    data_t  wb_head_data;
    mask_t  wb_head_mask;

    // Miss and refill
    logic   miss_req;
    addr_t  miss_addr;
    logic   fill_valid;
    word_t  fill_word;
    data_t  fill_data;
    logic   fill_last;

    dcache_front dcache_front_i (
        .clk            (clk),
        .rst            (rst),
        .i_read         (i_read),
        .i_read_addr    (i_read_addr),
        .i_write        (i_write),
        .i_write_addr   (i_write_addr),
        .i_write_data   (i_write_data),
        .i_write_mask   (i_write_mask),
        .i_wb_full      (wb_full),
        .i_fill_valid   (fill_valid),
        .i_fill_word    (fill_word),
        .i_fill_data    (fill_data),
        .i_fill_last    (fill_last),
        .o_read_done    (o_read_done),
        .o_read_data    (o_read_data),
        .o_write_done   (o_write_done),
        .o_wb_push      (wb_push),
        .o_wb_push_addr (wb_push_addr),
        .o_wb_push_data (wb_push_data),
        .o_wb_push_mask (wb_push_mask),
        .o_miss_req     (miss_req),
        .o_miss_addr    (miss_addr),
        .o_miss_way     ()
    );

    dcache_write_buffer dcache_write_buffer_i (
        .clk         (clk),
        .rst         (rst),
        .i_push      (wb_push),
        .i_push_addr (wb_push_addr),
        .i_push_data (wb_push_data),
        .i_push_mask (wb_push_mask),
        .i_pop       (wb_pop),
        .o_full      (wb_full),
        .o_empty     (wb_empty),
        .o_head_addr (wb_head_addr),
        .o_head_data (wb_head_data),
        .o_head_mask (wb_head_mask)
    );

    dcache_mem_seq dcache_mem_seq_i (
        .clk            (clk),
        .rst            (rst),
        .i_wb_empty     (wb_empty),
        .i_wb_head_addr (wb_head_addr),
        .i_wb_head_data (wb_head_data),
        .i_wb_head_mask (wb_head_mask),
        .i_miss_req     (miss_req),
        .i_miss_addr    (miss_addr),
        .i_mem_ready    (i_mem_ready),
        .i_mem_rvalid   (i_mem_rvalid),
        .i_mem_rdata    (i_mem_rdata),
        .o_wb_pop       (wb_pop),
        .o_mem_cmd      (o_mem_cmd),
        .o_mem_addr     (o_mem_addr),
        .o_mem_wdata    (o_mem_wdata),
        .o_mem_mask     (o_mem_mask),
        .o_fill_valid   (fill_valid),
        .o_fill_word    (fill_word),
        .o_fill_data    (fill_data),
        .o_fill_last    (fill_last)
    );

endmodule

/* tb/tb_mem_model.sv */
`timescale 1ns/1ps

module tb_mem_model (
    input  logic                 clk,
    input  logic                 rst,
    input  dcache_pkg::mem_cmd_t i_mem_cmd,
    input  dcache_pkg::addr_t    i_mem_addr,
    input  dcache_pkg::data_t    i_mem_wdata,
    input  dcache_pkg::mask_t    i_mem_mask,
    output logic                 o_mem_ready,
    output logic                 o_mem_rvalid,
    output dcache_pkg::data_t    o_mem_rdata
);
    import dcache_pkg::*;

    localparam int DEPTH = 256;

    data_t       mem_q [DEPTH];
    logic [1:0]  lat_q;

    // Byte address to word slot, 1 KB window
    function automatic int word_index(input addr_t addr);
        return int'(addr[9:2]);
    endfunction

    // Final content, read after the drain
    function automatic data_t peek_word(input addr_t addr);
        return mem_q[word_index(addr)];
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem_q[i] <= addr_t'(i * 4) ^ 32'ha5a5_0000;
            end
            o_mem_ready  <= 1'b0;
            o_mem_rvalid <= 1'b0;
            o_mem_rdata  <= '0;
            lat_q        <= 2'($urandom_range(3, 0));
        end else begin
            // Ready about half the time
            o_mem_ready  <= $urandom_range(1, 0) == 1;
            o_mem_rvalid <= 1'b0;
            if (i_mem_cmd == MEM_WRITE && o_mem_ready) begin
                for (int b = 0; b < MASK_W; b++) begin
                    if (i_mem_mask[b]) begin
                        mem_q[word_index(i_mem_addr)][8*b +: 8] <= i_mem_wdata[8*b +: 8];
                    end
                end
            end
            // One word per pulse, 1 to 4 cycles each
            if (i_mem_cmd == MEM_READ && !o_mem_rvalid) begin
                if (lat_q == 2'd0) begin
                    o_mem_rvalid <= 1'b1;
                    o_mem_rdata  <= mem_q[word_index(i_mem_addr)];
                    lat_q        <= 2'($urandom_range(3, 0));
                end else begin
                    lat_q <= lat_q - 2'd1;
                end
            end
        end
    end

endmodule

/* tb/tb_dcache.sv */
`timescale 1ns/1ps

module tb_dcache;
    import dcache_pkg::*;

    localparam int    CLK_PERIOD  = 40;
    localparam int    RST_CYCLES  = 5;
    localparam int    LINE_CYCLES = 200;
    localparam int    IDLE_CYCLES = 4;
    localparam string STIM_FILE   = "tb/dcache_stim.txt";

    logic       clk;
    logic       rst;
    logic       read_req;
    addr_t      read_addr;
    logic       read_done;
    data_t      read_data;
    logic       write_req;
    addr_t      write_addr;
    data_t      write_data;
    mask_t      write_mask;
    logic       write_done;
    mem_cmd_t   mem_cmd;
    addr_t      mem_addr;
    data_t      mem_wdata;
    mask_t      mem_mask;
    logic       mem_ready;
    logic       mem_rvalid;
    data_t      mem_rdata;

    // One entry per data line of the stimulus file
    logic [7:0] op_q   [$];
    addr_t      addr_q [$];
    data_t      data_q [$];
    mask_t      mask_q [$];
    int         lat_q  [$];

    int         n_lines;
    int         n_checks;
    int         n_errors;
    int         n_pass;
    int         n_fail;
    int         cur_test;
    int         test_errors;
    logic       test_open;
    logic       stim_ok;
    logic       drained;

    dcache_top dcache_top_i (
        .clk          (clk),
        .rst          (rst),
        .i_read       (read_req),
        .i_read_addr  (read_addr),
        .o_read_done  (read_done),
        .o_read_data  (read_data),
        .i_write      (write_req),
        .i_write_addr (write_addr),
        .i_write_data (write_data),
        .i_write_mask (write_mask),
        .o_write_done (write_done),
        .o_mem_cmd    (mem_cmd),
        .o_mem_addr   (mem_addr),
        .o_mem_wdata  (mem_wdata),
        .o_mem_mask   (mem_mask),
        .i_mem_ready  (mem_ready),
        .i_mem_rvalid (mem_rvalid),
        .i_mem_rdata  (mem_rdata)
    );

    tb_mem_model mem_model_i (
        .clk          (clk),
        .rst          (rst),
        .i_mem_cmd    (mem_cmd),
        .i_mem_addr   (mem_addr),
        .i_mem_wdata  (mem_wdata),
        .i_mem_mask   (mem_mask),
        .o_mem_ready  (mem_ready),
        .o_mem_rvalid (mem_rvalid),
        .o_mem_rdata  (mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////
    task automatic note_error();
        n_errors++;
        test_errors++;
    endtask

    task automatic check_read(input addr_t addr, input data_t got, input data_t exp);
        n_checks++;
        if (got !== exp) begin
            $display("error at %0t: load 0x%08h returned 0x%08h, expected 0x%08h",
                     $time, addr, got, exp);
            note_error();
        end
    endtask

    task automatic check_latency(input addr_t addr, input int got, input int exp);
        n_checks++;
        if (got != exp) begin
            $display("error at %0t: load 0x%08h took %0d cycles, expected %0d",
                     $time, addr, got, exp);
            note_error();
        end
    endtask

    task automatic check_mem_word(input addr_t addr, input data_t got, input data_t exp);
        n_checks++;
        if (got !== exp) begin
            $display("error at %0t: memory word 0x%08h holds 0x%08h, expected 0x%08h",
                     $time, addr, got, exp);
            note_error();
        end
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////
    task automatic read_stim(output logic ok);
        int         fd;
        int         n;
        string      line;
        logic [7:0] op;
        addr_t      a;
        data_t      d;
        mask_t      m;
        int         l;
        ok = 1'b0;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("cannot open stimulus file %s", STIM_FILE);
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                a = '0;
                d = '0;
                m = '0;
                l = 0;
                if (n > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%c %h %h %h %d", op, a, d, m, l);
                    if (n >= 2) begin
                        op_q.push_back(op);
                        addr_q.push_back(a);
                        data_q.push_back(d);
                        mask_q.push_back(m);
                        lat_q.push_back(l);
                    end
                end
            end
            $fclose(fd);
            n_lines = op_q.size();
            ok = n_lines > 0;
            if (!ok) begin
                $display("stimulus file %s holds no operations", STIM_FILE);
            end
        end
    endtask

    task automatic release_bus();
        @(posedge clk);
        read_req  <= 1'b0;
        write_req <= 1'b0;
    endtask

    task automatic run_load(input addr_t addr, input data_t exp, input int exp_lat);
        int   cycles;
        logic done;
        // Hit timing only holds once the last refill has ended
        if (exp_lat > 0) begin
            release_bus();
            @(negedge clk);
            while (mem_cmd == MEM_READ) begin
                @(negedge clk);
            end
        end
        @(posedge clk);
        read_req  <= 1'b1;
        read_addr <= addr;
        write_req <= 1'b0;
        cycles = 0;
        done = 1'b0;
        while (!done) begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
            done = read_done;
        end
        check_read(addr, read_data, exp);
        if (exp_lat > 0) begin
            check_latency(addr, cycles, exp_lat);
        end
    endtask

    task automatic run_store(input addr_t addr, input data_t data, input mask_t mask);
        logic done;
        @(posedge clk);
        read_req   <= 1'b0;
        write_req  <= 1'b1;
        write_addr <= addr;
        write_data <= data;
        write_mask <= mask;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = write_done;
        end
    endtask

    // Sequencer leaves idle at once while stores are buffered
    task automatic wait_drain();
        int idle;
        release_bus();
        idle = 0;
        while (idle < IDLE_CYCLES) begin
            @(negedge clk);
            if (mem_cmd == MEM_IDLE) begin
                idle++;
            end else begin
                idle = 0;
            end
        end
    endtask

    task automatic close_test();
        if (test_open) begin
            if (test_errors == 0) begin
                $display("test %0d passed", cur_test);
                n_pass++;
            end else begin
                $display("test %0d failed with %0d errors", cur_test, test_errors);
                n_fail++;
            end
            test_open = 1'b0;
        end
    endtask

    task automatic run_ops();
        foreach (op_q[i]) begin
            case (op_q[i])
                "T": begin
                    close_test();
                    cur_test    = int'(addr_q[i]);
                    test_errors = 0;
                    test_open   = 1'b1;
                end
                "R": run_load(addr_q[i], data_q[i], lat_q[i]);
                "W": run_store(addr_q[i], data_q[i], mask_q[i]);
                "M": begin
                    if (!drained) begin
                        wait_drain();
                        drained = 1'b1;
                    end
                    check_mem_word(addr_q[i], mem_model_i.peek_word(addr_q[i]), data_q[i]);
                end
                default: begin
                    $display("unknown operation '%c' in stimulus entry %0d", op_q[i], i);
                    note_error();
                end
            endcase
        end
        close_test();
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////
    initial begin
        void'($urandom(32'hdc553939));
        rst         = 1'b1;
        read_req    = 1'b0;
        read_addr   = '0;
        write_req   = 1'b0;
        write_addr  = '0;
        write_data  = '0;
        write_mask  = '0;
        n_lines     = 0;
        n_checks    = 0;
        n_errors    = 0;
        n_pass      = 0;
        n_fail      = 0;
        cur_test    = 0;
        test_errors = 0;
        test_open   = 1'b0;
        drained     = 1'b0;
        read_stim(stim_ok);
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
        if (stim_ok) begin
            run_ops();
        end
        release_bus();
        $display("%0d tests passed, %0d failed, %0d checks, %0d errors",
                 n_pass, n_fail, n_checks, n_errors);
        if (stim_ok && n_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Watchdog scaled by the number of stimulus lines
    initial begin
        wait (n_lines > 0);
        repeat (RST_CYCLES + n_lines * LINE_CYCLES) @(posedge clk);
        $display("timeout: run did not end within %0d cycles",
                 RST_CYCLES + n_lines * LINE_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

/* tb.f */
verilog/dcache_pkg.sv
verilog/dcache_way_ram.sv
verilog/dcache_front.sv
verilog/dcache_write_buffer.sv
verilog/dcache_mem_seq.sv
verilog/dcache_top.sv
tb/tb_mem_model.sv
tb/tb_dcache.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module tb_dcache -f tb.f -o tb_dcache_sim

./obj_dir/tb_dcache_sim > sim.log 2>&1
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
    exit 1
fi
exit 0

/* tb/dcache_stim.txt */
# op addr data mask lat  (T test number, R load, W store, M final memory word)
# R data is the expected load value; lat 1 checks hit timing, 0 skips it
T 1
R 00000040 a5a50040 0 0
R 00000040 a5a50040 0 1
T 2
R 00000058 a5a50058 0 0
W 00000054 11223344 3 0
R 00000054 a5a53344 0 1
R 0000005c a5a5005c 0 1
R 00000050 a5a50050 0 1
W 000000a8 deadbeef c 0
R 000000a8 dead00a8 0 0
T 3
R 00000034 a5a50034 0 0
R 00000134 a5a50134 0 0
R 00000034 a5a50034 0 1
R 00000230 a5a50230 0 0
R 00000038 a5a50038 0 1
R 00000130 a5a50130 0 0
T 4
W 00000100 11111111 f 0
W 00000104 22222222 f 0
W 00000108 33333333 3 0
W 00000108 44444444 c 0
W 0000010c 55555555 f 0
R 00000108 44443333 0 0
R 0000010c 55555555 0 1
T 5
M 00000054 a5a53344 0 0
M 00000058 a5a50058 0 0
M 000000a8 dead00a8 0 0
M 00000100 11111111 0 0
M 00000104 22222222 0 0
M 00000108 44443333 0 0
M 0000010c 55555555 0 0
M 00000230 a5a50230 0 0
